// ==== Bender.yml ====
package:
  name: uart_rx

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - uart_cfg_pkg.sv
      - uart_rx_pkg.sv
      - rx_fifo_if.sv
      - rx_frame_fsm.sv
      - rx_fifo.sv
      - rx_ready_irq.sv
      - uart_rx_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_uart_rx_checker.sv
      - tb_uart_rx.sv

// ==== rx_fifo.sv ====
/*
 * First-word-fall-through FIFO of receiver status words
 * Writes while full are dropped and reads while empty are ignored
 * The head word is meaningful only while empty is low
 */

`default_nettype none

`include "uart_rx_defines.svh"

module rx_fifo
  import uart_rx_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  rx_fifo_if.store fifo
);

  localparam int unsigned DEPTH = `RX_FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  rx_word_t             mem [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [`RX_CNT_W-1:0] count_q;
  logic [`RX_CNT_W-1:0] count_d;
  logic                 empty_q;
  logic                 full_q;
  logic                 do_wr;
  logic                 do_rd;

  // Accepted operations after the full and empty guards
  assign do_wr = fifo.write && !full_q;
  assign do_rd = fifo.read && !empty_q;

  // A read and a write together leave the level unchanged
  always_comb begin
    case ({do_wr, do_rd})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
  end

  // Pointers wrap explicitly so any depth works
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      empty_q  <= 1'b1;
      full_q   <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_d;
      // Flags are registered from the next count to keep them glitch free
      empty_q <= (count_d == '0);
      full_q  <= (count_d == DEPTH);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= fifo.wr_word;
    end
  end

  // Head of the queue falls through without a read latency
  assign fifo.rd_word = mem[rd_ptr_q];
  assign fifo.empty   = empty_q;
  assign fifo.full    = full_q;
  assign fifo.count   = count_q;

  a_count_max : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= DEPTH);

  // Pointers meet only when the count says empty or full
  a_empty_count : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wr_ptr_q == rd_ptr_q) == (count_q == '0 || count_q == DEPTH));

endmodule : rx_fifo

`default_nettype wire

// ==== rx_fifo_if.sv ====
/*
 * Internal link between the frame FSM, the receive FIFO and the ready logic
 * Strobes carry no handshake and a write into a full FIFO is lost
 */

`default_nettype none

`include "uart_rx_defines.svh"

interface rx_fifo_if
  import uart_rx_pkg::*;
();

  // Write side, driven by the frame FSM for a single cycle per character
  logic     write;
  rx_word_t wr_word;

  // Read strobe from the host side of the receiver
  logic     read;

  // FIFO state, the head word is valid whenever empty is low
  rx_word_t              rd_word;
  logic                  empty;
  logic                  full;
  logic [`RX_CNT_W-1:0]  count;

  // Frame FSM pushes words and only needs to know when they would be lost
  modport producer (
    output write,
    output wr_word,
    input  full
  );

  // The FIFO itself owns the head word and all status
  modport store (
    input  write,
    input  wr_word,
    input  read,
    output rd_word,
    output empty,
    output full,
    output count
  );

  // Ready interrupt logic only observes the traffic and the fill level
  modport monitor (
    input write,
    input read,
    input count,
    input empty
  );

endinterface : rx_fifo_if

`default_nettype wire

// ==== rx_frame_fsm.sv ====
/*
 * Oversampled UART frame receiver, 16 ticks per bit on ov_baud_rt_i
 * The start bit is not re-checked at its middle, a glitch starts a frame
 * Every stop bit sampled low flags a frame error in the status word
 */

`default_nettype none

`include "uart_rx_defines.svh"

module rx_frame_fsm
  import uart_cfg_pkg::*, uart_rx_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         enable_i,
  input  logic         ov_baud_rt_i,
  input  logic         rx_i,
  input  data_width_e  data_width_i,
  input  parity_mode_e parity_mode_i,
  input  stop_bits_e   stop_bits_number_i,
  input  logic         rxd_rdy_i,
  output logic         rx_done_o,
  rx_fifo_if.producer  fifo
);

  localparam int unsigned OVS_W = $clog2(`OVS_RATE);
  localparam int unsigned BIT_W = $clog2(`DATA_W);

  rx_state_e          state_q;
  logic [OVS_W-1:0]   ovs_cnt_q;
  logic [BIT_W-1:0]   bit_cnt_q;
  logic [BIT_W-1:0]   last_bit;
  logic               stop_cnt_q;
  logic               stop_ok_q;
  logic [`DATA_W-1:0] shift_q;
  logic               par_q;
  logic               par_en;
  logic               mid_tick;
  logic               smp_tick;
  logic               last_stop;
  logic               done;
  logic [`DATA_W-1:0] rx_data;

  // ------------------------------------------------------------------------
  // Tick strobes
  // ------------------------------------------------------------------------

  // Middle of the start bit is reached after OVS_MID+1 ticks
  assign mid_tick = ov_baud_rt_i && (state_q == ST_START) &&
                    (ovs_cnt_q == OVS_W'(`OVS_MID));

  // From there every full bit period lands again in the middle of a bit
  assign smp_tick = ov_baud_rt_i && (state_q inside {ST_DATA, ST_PARITY, ST_STOP}) &&
                    (ovs_cnt_q == OVS_W'(`OVS_RATE - 1));

  // Index of the last data bit, the width code is width minus five
  assign last_bit  = BIT_W'({1'b0, data_width_i} + 3'd4);
  assign par_en    = !parity_mode_i[1];
  assign last_stop = (stop_bits_number_i != SB_2BIT) || stop_cnt_q;

  // The counter restarts on every sample so the next one is a bit later
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ovs_cnt_q <= '0;
    end else if (state_q == ST_IDLE || mid_tick || smp_tick) begin
      ovs_cnt_q <= '0;
    end else if (ov_baud_rt_i) begin
      ovs_cnt_q <= ovs_cnt_q + 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Frame sequencing
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      bit_cnt_q  <= '0;
      stop_cnt_q <= 1'b0;
      stop_ok_q  <= 1'b1;
    end else begin
      case (state_q)
        // Falling edge on the line while enabled starts a frame
        ST_IDLE: begin
          if (enable_i && !rx_i) begin
            state_q <= ST_START;
          end
        end
        ST_START: begin
          if (mid_tick) begin
            bit_cnt_q <= '0;
            state_q   <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (smp_tick) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == last_bit) begin
              stop_cnt_q <= 1'b0;
              stop_ok_q  <= 1'b1;
              state_q    <= par_en ? ST_PARITY : ST_STOP;
            end
          end
        end
        ST_PARITY: begin
          if (smp_tick) begin
            state_q <= ST_STOP;
          end
        end
        ST_STOP: begin
          if (smp_tick) begin
            // A low first stop bit must survive into the second one
            stop_ok_q  <= stop_ok_q & rx_i;
            stop_cnt_q <= 1'b1;
            if (last_stop) begin
              state_q <= ST_IDLE;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Data arrives LSB first so each bit enters at the top and moves down
  always_ff @(posedge clk_i) begin
    if (smp_tick && state_q == ST_DATA) begin
      shift_q <= {rx_i, shift_q[`DATA_W-1:1]};
    end
    if (smp_tick && state_q == ST_PARITY) begin
      par_q <= rx_i;
    end
  end

  // ------------------------------------------------------------------------
  // Status word
  // ------------------------------------------------------------------------

  // Narrow characters stop short of bit 0 and need a right shift
  always_comb begin
    case (data_width_i)
      DW_5BIT: rx_data = {3'b000, shift_q[7:3]};
      DW_6BIT: rx_data = {2'b00, shift_q[7:2]};
      DW_7BIT: rx_data = {1'b0, shift_q[7:1]};
      default: rx_data = shift_q;
    endcase
  end

  // Character ends on the tick that samples the last stop bit
  assign done      = smp_tick && (state_q == ST_STOP) && last_stop;
  assign rx_done_o = done;

  // The pulse still happens when the FIFO is full, only the write is lost
  assign fifo.write = done && !fifo.full;

  assign fifo.wr_word.data       = rx_data;
  // Odd parity inverts the expected bit via the low mode bit
  assign fifo.wr_word.parity_err = par_en && (par_q ^ (^rx_data) ^ parity_mode_i[0]);
  assign fifo.wr_word.frame_err  = !(stop_ok_q & rx_i);
  // A character still waiting to be serviced is about to be overtaken
  assign fifo.wr_word.overrun    = rxd_rdy_i;

  // ------------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------------

  // Receiver stays idle while disabled
  a_idle_enable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == ST_IDLE && !enable_i) |=> (state_q == ST_IDLE));

  // Writes come from the last stop sample and end the frame
  a_write_stop : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fifo.write |-> (state_q == ST_STOP && ov_baud_rt_i) ##1 (state_q == ST_IDLE));

endmodule : rx_frame_fsm

`default_nettype wire

// ==== rx_ready_irq.sv ====
/*
 * Ready interrupt for the receive FIFO
 * Standard mode flags every character, data stream mode flags a fill level
 * Threshold 0 in data stream mode means the FIFO has to be full
 */

`default_nettype none

`include "uart_rx_defines.svh"

module rx_ready_irq (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 rx_data_stream_mode_i,
  input  logic [`RX_CNT_W-1:0] threshold_i,
  output logic                 rxd_rdy_o,
  rx_fifo_if.monitor           mon
);

  localparam int unsigned DEPTH = `RX_FIFO_DEPTH;

  logic [`RX_CNT_W-1:0] post_cnt;
  logic                 thr_hit;
  logic                 set_rdy;
  logic                 clr_rdy;
  logic                 rdy_q;

  // Fill level as it will be once the current write lands
  // A write is never issued while full so this cannot overflow
  assign post_cnt = mon.count + 1'b1;

  assign thr_hit = (threshold_i == '0) ? (post_cnt == DEPTH) : (post_cnt >= threshold_i);

  assign set_rdy = mon.write && (!rx_data_stream_mode_i || thr_hit);

  // Standard mode is serviced by the read itself
  // Data stream mode stays pending until the host has drained everything
  assign clr_rdy = rx_data_stream_mode_i ? mon.empty : mon.read;

  // A new character wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdy_q <= 1'b0;
    end else if (set_rdy) begin
      rdy_q <= 1'b1;
    end else if (clr_rdy) begin
      rdy_q <= 1'b0;
    end
  end

  assign rxd_rdy_o = rdy_q;

  // In standard mode every stored character raises the interrupt
  // and leaves a word waiting in the FIFO
  a_std_raise : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!rx_data_stream_mode_i && mon.write) |=> (rxd_rdy_o && !mon.empty));

endmodule : rx_ready_irq

`default_nettype wire

// ==== sources.f ====
+incdir+.
uart_cfg_pkg.sv
uart_rx_pkg.sv
rx_fifo_if.sv
rx_frame_fsm.sv
rx_fifo.sv
rx_ready_irq.sv
uart_rx_top.sv
tb_uart_rx_checker.sv
tb_uart_rx.sv

// ==== tb_uart_rx.sv ====
/*
 * Testbench for the UART receiver, driven only through its top level ports
 * ov_baud_rt_i pulses every second clock, so one serial bit lasts 32 clocks
 * Random data and formats come from $urandom with a fixed seed
 */

`default_nettype none

`include "uart_rx_defines.svh"

module tb_uart_rx
  import uart_cfg_pkg::*, uart_rx_pkg::*;
();

  localparam int unsigned BIT_CYC      = `OVS_RATE * 2;
  localparam int unsigned MAX_BITS     = 12;
  localparam int unsigned N_RAND       = 24;
  localparam int unsigned N_PAR        = 6;
  localparam int unsigned THR          = 5;
  localparam int unsigned FRAMES       = N_RAND + N_PAR + 3 + 2 + THR + `RX_FIFO_DEPTH + 1;
  localparam int unsigned WD_CYCLES    = 2 * FRAMES * MAX_BITS * BIT_CYC;
  localparam int unsigned DONE_TIMEOUT = 2 * MAX_BITS * BIT_CYC;

  logic                 clk;
  logic                 rst_n;
  logic                 enable;
  logic                 ov_tick;
  logic                 rx_line;
  logic                 fifo_read;
  logic [`RX_CNT_W-1:0] threshold;
  logic                 ds_mode;
  data_width_e          data_width;
  stop_bits_e           stop_bits;
  parity_mode_e         parity_mode;
  logic                 fifo_full;
  logic                 fifo_empty;
  logic                 rx_done;
  logic                 rxd_rdy;
  logic [`DATA_W-1:0]   data_rx;
  logic                 frame_err;
  logic                 parity_err;
  logic                 overrun_err;
  int unsigned          chk_errs;
  int unsigned          top_errs;
  int unsigned          test_fails;
  int unsigned          errs_at_start;
  int unsigned          done_cnt;
  int                   test_no;
  string                test_name;

  uart_rx_top UUT (
    .clk_i                 (clk),
    .rst_n_i               (rst_n),
    .enable_i              (enable),
    .ov_baud_rt_i          (ov_tick),
    .rx_i                  (rx_line),
    .rx_fifo_read_i        (fifo_read),
    .threshold_i           (threshold),
    .rx_data_stream_mode_i (ds_mode),
    .data_width_i          (data_width),
    .stop_bits_number_i    (stop_bits),
    .parity_mode_i         (parity_mode),
    .rx_fifo_full_o        (fifo_full),
    .rx_fifo_empty_o       (fifo_empty),
    .rx_done_o             (rx_done),
    .rxd_rdy_o             (rxd_rdy),
    .data_rx_o             (data_rx),
    .frame_error_o         (frame_err),
    .parity_error_o        (parity_err),
    .overrun_error_o       (overrun_err)
  );

  tb_uart_rx_checker u_checker (
    .clk_i                 (clk),
    .rst_n_i               (rst_n),
    .rx_done_i             (rx_done),
    .rx_fifo_read_i        (fifo_read),
    .rxd_rdy_i             (rxd_rdy),
    .rx_data_stream_mode_i (ds_mode),
    .threshold_i           (threshold),
    .data_rx_i             (data_rx),
    .frame_error_i         (frame_err),
    .parity_error_i        (parity_err),
    .overrun_error_i       (overrun_err),
    .err_cnt_o             (chk_errs)
  );

  // --------------------------------------------------------------------------
  // Clock, oversample tick and done counter
  // --------------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      ov_tick  <= 1'b0;
      done_cnt <= 0;
    end else begin
      ov_tick <= !ov_tick;
      if (rx_done) begin
        done_cnt <= done_cnt + 1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Reference model and helpers
  // --------------------------------------------------------------------------

  // Expected status word, built from the frame as it was put on the line
  function automatic rx_word_t ref_word(input logic [7:0] data, input data_width_e dw,
                                        input parity_mode_e pm, input logic bad_par,
                                        input logic bad_stop, input logic ovr);
    rx_word_t    w;
    int unsigned width;
    width        = 5 + int'(dw);
    w.data       = data & (8'hff >> (8 - width));
    // Without parity a flipped parity bit is never even sent
    w.parity_err = !pm[1] && bad_par;
    w.frame_err  = bad_stop;
    w.overrun    = ovr;
    return w;
  endfunction

  task automatic fail_note(input string msg);
    $display("Test %0d: %s", test_no, msg);
    top_errs++;
  endtask

  task automatic expect_rdy(input logic exp, input string what);
    if (rxd_rdy !== exp) begin
      $display("ERR rxd_rdy_o %s expected 0x%0h got 0x%0h", what, exp, rxd_rdy);
      top_errs++;
    end
  endtask

  task automatic set_format(input data_width_e dw, input parity_mode_e pm,
                            input stop_bits_e sb);
    data_width  <= dw;
    parity_mode <= pm;
    stop_bits   <= sb;
    @(posedge clk);
  endtask

  // The line goes idle as soon as the frame ends, so a low stop bit
  // cannot be taken for the next start bit
  task automatic drive_bit(input logic val);
    rx_line <= val;
    repeat (BIT_CYC) begin
      @(posedge clk);
      if (rx_done) begin
        rx_line <= 1'b1;
      end
    end
  endtask

  // stop_low selects no bad stop bit (0), the first (1) or the second (2)
  task automatic send_frame(input logic [7:0] data, input logic bad_par, input int stop_low);
    int unsigned width;
    logic [7:0]  d;
    width = 5 + int'(data_width);
    d     = data & (8'hff >> (8 - width));
    drive_bit(1'b0);
    for (int unsigned i = 0; i < width; i++) begin
      drive_bit(d[i]);
    end
    if (!parity_mode[1]) begin
      drive_bit((^d) ^ parity_mode[0] ^ bad_par);
    end
    drive_bit(stop_low != 1);
    if (stop_bits == SB_2BIT) begin
      drive_bit(stop_low != 2);
    end
  endtask

  task automatic wait_done(input int unsigned target);
    int unsigned n;
    n = 0;
    while (done_cnt < target && n < DONE_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (done_cnt < target) begin
      fail_note("rx_done_o never pulsed for the frame just sent");
    end
  endtask

  // Words that the FIFO is expected to drop are sent but not queued
  task automatic receive_frame(input logic [7:0] data, input logic bad_par, input int stop_low,
                               input logic ovr, input logic keep);
    rx_word_t    w;
    int unsigned target;
    w = ref_word(data, data_width, parity_mode, bad_par, stop_low != 0, ovr);
    if (keep) begin
      u_checker.push_word(w);
    end
    target = done_cnt + 1;
    send_frame(data, bad_par, stop_low);
    wait_done(target);
  endtask

  task automatic read_word();
    if (fifo_empty) begin
      fail_note("FIFO was empty where a word should have been waiting");
    end else begin
      fifo_read <= 1'b1;
      @(posedge clk);
      fifo_read <= 1'b0;
      @(posedge clk);
    end
  endtask

  task automatic begin_test(input int no, input string name);
    test_no       = no;
    test_name     = name;
    errs_at_start = top_errs + chk_errs;
  endtask

  task automatic end_test();
    int unsigned errs;
    @(posedge clk);
    if (u_checker.pending() != 0) begin
      fail_note("some expected words were never read back");
    end
    errs = top_errs + chk_errs - errs_at_start;
    if (errs == 0) begin
      $display("Test %0d (%s) passed", test_no, test_name);
    end else begin
      $display("Test %0d (%s) failed with %0d errors", test_no, test_name, errs);
      test_fails++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  initial begin
    int unsigned  n;
    int unsigned  total;
    parity_mode_e pm;
    void'($urandom(32'hd9f3));
    rst_n       <= 1'b0;
    enable      <= 1'b0;
    ov_tick     <= 1'b0;
    rx_line     <= 1'b1;
    fifo_read   <= 1'b0;
    threshold   <= '0;
    ds_mode     <= 1'b0;
    data_width  <= DW_8BIT;
    stop_bits   <= SB_1BIT;
    parity_mode <= PAR_NONE;
    repeat (10) @(posedge clk);
    rst_n  <= 1'b1;
    enable <= 1'b1;
    @(posedge clk);

    begin_test(1, "standard mode, random formats");
    repeat (N_RAND) begin
      set_format(data_width_e'($urandom % 4), parity_mode_e'($urandom % 3),
                 stop_bits_e'($urandom % 2));
      receive_frame(8'($urandom), 1'b0, 0, 1'b0, 1'b1);
      expect_rdy(1'b1, "after a frame");
      read_word();
      expect_rdy(1'b0, "after the read");
    end
    end_test();

    begin_test(2, "parity errors");
    for (n = 0; n < N_PAR; n++) begin
      // The last frames repeat the flip with parity switched off
      if (n < 4) begin
        pm = (n % 2 == 1) ? PAR_ODD : PAR_EVEN;
      end else begin
        pm = PAR_NONE;
      end
      set_format(data_width_e'(n % 4), pm, stop_bits_e'(n % 2));
      receive_frame(8'($urandom), 1'b1, 0, 1'b0, 1'b1);
      read_word();
    end
    end_test();

    begin_test(3, "frame errors");
    set_format(DW_8BIT, PAR_EVEN, SB_1BIT);
    receive_frame(8'($urandom), 1'b0, 1, 1'b0, 1'b1);
    read_word();
    set_format(DW_7BIT, PAR_NONE, SB_2BIT);
    receive_frame(8'($urandom), 1'b0, 1, 1'b0, 1'b1);
    read_word();
    set_format(DW_6BIT, PAR_ODD, SB_2BIT);
    receive_frame(8'($urandom), 1'b0, 2, 1'b0, 1'b1);
    read_word();
    end_test();

    begin_test(4, "overrun");
    set_format(DW_8BIT, PAR_EVEN, SB_1BIT);
    receive_frame(8'($urandom), 1'b0, 0, 1'b0, 1'b1);
    receive_frame(8'($urandom), 1'b0, 0, 1'b1, 1'b1);
    read_word();
    read_word();
    expect_rdy(1'b0, "after both reads");
    end_test();

    begin_test(5, "data stream threshold");
    ds_mode   <= 1'b1;
    threshold <= `RX_CNT_W'(THR);
    set_format(DW_8BIT, PAR_NONE, SB_1BIT);
    for (n = 0; n < THR; n++) begin
      receive_frame(8'($urandom), 1'b0, 0, 1'b0, 1'b1);
      if (n < THR - 1) begin
        expect_rdy(1'b0, "below the threshold");
      end else begin
        expect_rdy(1'b1, "at the threshold");
      end
    end
    for (n = 0; n < THR; n++) begin
      read_word();
      if (n < THR - 1) begin
        expect_rdy(1'b1, "while the FIFO drains");
      end
    end
    @(posedge clk);
    expect_rdy(1'b0, "once the FIFO is empty");
    end_test();

    begin_test(6, "full FIFO");
    threshold <= '0;
    @(posedge clk);
    for (n = 0; n < `RX_FIFO_DEPTH; n++) begin
      receive_frame(8'($urandom), 1'b0, 0, 1'b0, 1'b1);
    end
    expect_rdy(1'b1, "with the FIFO full");
    if (fifo_full !== 1'b1) begin
      fail_note("rx_fifo_full_o stayed low after filling the FIFO");
    end
    // One more frame still ends with a done pulse but is lost
    receive_frame(8'($urandom), 1'b0, 0, 1'b0, 1'b0);
    n = 0;
    while (!fifo_empty && n <= `RX_FIFO_DEPTH) begin
      read_word();
      n++;
    end
    if (n != `RX_FIFO_DEPTH) begin
      fail_note($sformatf("read back %0d words instead of %0d", n, `RX_FIFO_DEPTH));
    end
    @(posedge clk);
    expect_rdy(1'b0, "once the FIFO is empty");
    end_test();

    @(posedge clk);
    total = top_errs + chk_errs;
    $display("Tests run 6, tests failed %0d, errors %0d", test_fails, total);
    if (total == 0 && test_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Bound is twice the longest possible duration of every frame sent
  initial begin
    repeat (WD_CYCLES + 20) @(posedge clk);
    $display("Watchdog expired, test %0d (%s) hung", test_no, test_name);
    $display("** FAIL **");
    $finish;
  end

endmodule : tb_uart_rx

`default_nettype wire

// ==== tb_uart_rx_checker.sv ====
/*
 * Watches the receiver ports and compares each popped word with the queue
 * Expected words must be pushed in frame order before they are read
 * The ready flag is checked in the cycle after each rx_done_o pulse
 */

`default_nettype none

`include "uart_rx_defines.svh"

module tb_uart_rx_checker
  import uart_rx_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 rx_done_i,
  input  logic                 rx_fifo_read_i,
  input  logic                 rxd_rdy_i,
  input  logic                 rx_data_stream_mode_i,
  input  logic [`RX_CNT_W-1:0] threshold_i,
  input  logic [`DATA_W-1:0]   data_rx_i,
  input  logic                 frame_error_i,
  input  logic                 parity_error_i,
  input  logic                 overrun_error_i,
  output int unsigned          err_cnt_o
);

  localparam int unsigned DEPTH = `RX_FIFO_DEPTH;

  rx_word_t    exp_q [$];
  rx_word_t    exp;
  int unsigned level;
  int unsigned post;
  logic        wr;
  logic        rd;
  logic        hit;
  logic        set_rdy;
  logic        clr_rdy;
  logic        rdy_model;
  logic        done_seen;

  task automatic push_word(input rx_word_t w);
    exp_q.push_back(w);
  endtask

  function automatic int unsigned pending();
    return exp_q.size();
  endfunction

  task automatic compare_val(input string name, input logic [7:0] exp_v, input logic [7:0] got);
    if (got !== exp_v) begin
      $display("ERR %s expected 0x%0h got 0x%0h", name, exp_v, got);
      err_cnt_o++;
    end
  endtask

  // ----------------------------------------------------------------------------
  // Fill level and ready model
  // ----------------------------------------------------------------------------

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      level     = 0;
      rdy_model = 1'b0;
      done_seen = 1'b0;
    end else begin
      if (done_seen) begin
        compare_val("rxd_rdy_o", 8'(rdy_model), 8'(rxd_rdy_i));
      end
      // Frames that end with a full FIFO are lost
      wr   = rx_done_i && (level != DEPTH);
      rd   = rx_fifo_read_i && (level != 0);
      post = level + 1;
      // Threshold 0 waits for a full FIFO
      hit  = (threshold_i == 0) ? (post == DEPTH) : (post >= threshold_i);
      set_rdy = wr && (!rx_data_stream_mode_i || hit);
      clr_rdy = rx_data_stream_mode_i ? (level == 0) : rx_fifo_read_i;
      if (rd) begin
        if (exp_q.size() == 0) begin
          $display("A read popped a word that no sent frame should have left");
          err_cnt_o++;
        end else begin
          exp = exp_q.pop_front();
          compare_val("data_rx_o", exp.data, data_rx_i);
          compare_val("parity_error_o", 8'(exp.parity_err), 8'(parity_error_i));
          compare_val("frame_error_o", 8'(exp.frame_err), 8'(frame_error_i));
          compare_val("overrun_error_o", 8'(exp.overrun), 8'(overrun_error_i));
        end
      end
      if (wr && !rd) begin
        level = level + 1;
      end else if (rd && !wr) begin
        level = level - 1;
      end
      // A new word wins over a clear in the same cycle
      if (set_rdy) begin
        rdy_model = 1'b1;
      end else if (clr_rdy) begin
        rdy_model = 1'b0;
      end
      done_seen = rx_done_i;
    end
  end

endmodule : tb_uart_rx_checker

`default_nettype wire

// ==== uart_cfg_pkg.sv ====
/*
 * Line format encodings as seen on the configuration ports
 * Parity mode 2'b11 is not named but behaves exactly like PAR_NONE
 */

`default_nettype none

package uart_cfg_pkg;

  // Number of data bits per character, encoded as width minus five
  typedef enum logic [1:0] {
    DW_5BIT = 2'b00,
    DW_6BIT = 2'b01,
    DW_7BIT = 2'b10,
    DW_8BIT = 2'b11
  } data_width_e;

  // Parity is checked only while the upper bit is clear
  // The lower bit then selects odd parity
  typedef enum logic [1:0] {
    PAR_EVEN = 2'b00,
    PAR_ODD  = 2'b01,
    PAR_NONE = 2'b10
  } parity_mode_e;

  // Anything other than SB_2BIT is handled as a single stop bit
  typedef enum logic [1:0] {
    SB_1BIT = 2'b00,
    SB_2BIT = 2'b01
  } stop_bits_e;

endpackage : uart_cfg_pkg

`default_nettype wire

// ==== uart_rx_defines.svh ====
/*
 * Receiver sizing constants shared by the packages, the RTL and the testbench
 * RX_CNT_W must hold the value RX_FIFO_DEPTH itself, not only DEPTH-1
 * OVS_RATE is assumed to be a power of two and DATA_W is fixed at 8 bits
 */

`ifndef UART_RX_DEFINES_SVH
`define UART_RX_DEFINES_SVH

// Number of status words the receive FIFO can hold
`define RX_FIFO_DEPTH 32

// Width of the fill count and of the threshold input
`define RX_CNT_W 6

// Oversample ticks per bit and the tick count at the middle of the start bit
`define OVS_RATE 16
`define OVS_MID 7

// Width of the data field in the status word
`define DATA_W 8

`endif

// ==== uart_rx_pkg.sv ====
/*
 * Types private to the receiver
 * The status word layout puts data in the low bits and the flags on top
 */

`default_nettype none

`include "uart_rx_defines.svh"

package uart_rx_pkg;

  // Frame FSM states, one per field of the serial frame
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_PARITY,
    ST_STOP
  } rx_state_e;

  // One received character as stored in the FIFO
  // Data is right aligned and zero above the configured width
  typedef struct packed {
    logic              overrun;
    logic              frame_err;
    logic              parity_err;
    logic [`DATA_W-1:0] data;
  } rx_word_t;

endpackage : uart_rx_pkg

`default_nettype wire

// ==== uart_rx_top.sv ====
/*
 * UART receiver with a status word FIFO and a ready interrupt
 * Error outputs are only valid in the cycle that pops their word
 * rx_fifo_full_o is a plain level and full drops incoming characters
 */

`default_nettype none

`include "uart_rx_defines.svh"

module uart_rx_top
  import uart_cfg_pkg::*, uart_rx_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 enable_i,
  input  logic                 ov_baud_rt_i,
  input  logic                 rx_i,
  input  logic                 rx_fifo_read_i,
  input  logic [`RX_CNT_W-1:0] threshold_i,
  input  logic                 rx_data_stream_mode_i,
  input  data_width_e          data_width_i,
  input  stop_bits_e           stop_bits_number_i,
  input  parity_mode_e         parity_mode_i,
  output logic                 rx_fifo_full_o,
  output logic                 rx_fifo_empty_o,
  output logic                 rx_done_o,
  output logic                 rxd_rdy_o,
  output logic [`DATA_W-1:0]   data_rx_o,
  output logic                 frame_error_o,
  output logic                 parity_error_o,
  output logic                 overrun_error_o
);

  rx_fifo_if fifo_if ();

  rx_word_t head_word;
  logic     rdy;

  assign fifo_if.read = rx_fifo_read_i;

  // ------------------------------------------------------------------------
  // Receive path
  // ------------------------------------------------------------------------

  rx_frame_fsm u_frame_fsm (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .enable_i           (enable_i),
    .ov_baud_rt_i       (ov_baud_rt_i),
    .rx_i               (rx_i),
    .data_width_i       (data_width_i),
    .parity_mode_i      (parity_mode_i),
    .stop_bits_number_i (stop_bits_number_i),
    .rxd_rdy_i          (rdy),
    .rx_done_o          (rx_done_o),
    .fifo               (fifo_if.producer)
  );

  rx_fifo u_rx_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .fifo    (fifo_if.store)
  );

  // Pending interrupt also tags the next character as an overrun
  rx_ready_irq u_ready_irq (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .rx_data_stream_mode_i (rx_data_stream_mode_i),
    .threshold_i           (threshold_i),
    .rxd_rdy_o             (rdy),
    .mon                   (fifo_if.monitor)
  );

  // ------------------------------------------------------------------------
  // Host side outputs
  // ------------------------------------------------------------------------

  assign head_word       = fifo_if.rd_word;
  assign data_rx_o       = head_word.data;
  assign rxd_rdy_o       = rdy;
  assign rx_fifo_full_o  = fifo_if.full;
  assign rx_fifo_empty_o = fifo_if.empty;

  // Flags show up as one cycle pulses together with the popping read
  assign frame_error_o   = head_word.frame_err & rx_fifo_read_i;
  assign parity_error_o  = head_word.parity_err & rx_fifo_read_i;
  assign overrun_error_o = head_word.overrun & rx_fifo_read_i;

endmodule : uart_rx_top

`default_nettype wire
